/* rtl/riscvPkg.sv */
package riscvPkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int xlen     = 32;
    localparam int romDepth = 64;  // Instruction words.
    localparam int ramDepth = 64;  // Data words.

    localparam string romFile = "program.hex";

    // addi x0, x0, 0 is the canonical no-op.
    localparam logic [xlen-1:0] nopInstr = 32'h0000_0013;

    // ----------------------------------------
    // Opcodes and function fields
    // ----------------------------------------
    localparam logic [6:0] opR     = 7'b0110011;
    localparam logic [6:0] opI     = 7'b0010011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSrl, aluSra,
        aluSlt, aluSltu, aluXor, aluOr, aluAnd
    } aluOp_t;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    // The same word seen through each of the three layouts.
    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
    } instr_t;

endpackage

/* rtl/Alu.sv */
`timescale 1ns/100ps

module Alu import riscvPkg::*; (
    input  aluOp_t      aluOp,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);
    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only the low five bits shift.

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluSll:  result = a << shamt;
            aluSrl:  result = a >> shamt;
            aluSra:  result = $signed(a) >>> shamt;
            aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
            aluSltu: result = {31'b0, a < b};
            aluXor:  result = a ^ b;
            aluOr:   result = a | b;
            aluAnd:  result = a & b;
            default: result = 'x;
        endcase
    end

    // An out-of-range code from the decoder would show up here as X.
    always_comb begin
        assert final ($isunknown({aluOp, a, b}) || !$isunknown(result))
            else $error("ALU result unknown for aluOp %0d.", aluOp);
    end

endmodule

/* rtl/RegisterFile.sv */
`timescale 1ns/100ps

module RegisterFile (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [4:0]  rAddr1,
    input  logic [4:0]  rAddr2,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData,
    output logic [31:0] rData1,
    output logic [31:0] rData2
);
    logic [31:0] regs [32];

    // Reset loads 10 + i into every register so stores show a known image.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'(10 + i);
            end
        end else if (we && (wAddr != 5'd0)) begin
            regs[wAddr] <= wData;
        end
    end

    // x0 is hardwired to zero on both ports.
    assign rData1 = (rAddr1 == 5'd0) ? '0 : regs[rAddr1];
    assign rData2 = (rAddr2 == 5'd0) ? '0 : regs[rAddr2];

endmodule

/* rtl/DataPath.sv */
`timescale 1ns/100ps

module DataPath import riscvPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  instr_t      instr,
    input  logic        regWe,
    input  logic        aluSrcImm,
    input  logic        memToReg,
    input  aluOp_t      aluOp,
    input  logic [31:0] ramRData,
    output logic [31:0] pc,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWData
);
    logic [xlen-1:0] pcNext;
    logic [xlen-1:0] immExt;
    logic [xlen-1:0] rData1, rData2;
    logic [xlen-1:0] aluB, aluResult;
    logic [xlen-1:0] wbData;

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    assign pcNext = pc + 32'd4;  // No branches, so always the next word.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Stores split the immediate, everything else uses the I layout.
    always_comb begin
        if (instr.r.opcode == opStore) begin
            immExt = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
        end else begin
            immExt = {{20{instr.i.imm[11]}}, instr.i.imm};
        end
    end

    assign aluB   = aluSrcImm ? immExt : rData2;
    assign wbData = memToReg ? ramRData : aluResult;

    RegisterFile uRegFile (
        .clk    (clk),
        .reset  (reset),
        .we     (regWe),
        .rAddr1 (instr.r.rs1),
        .rAddr2 (instr.r.rs2),
        .wAddr  (instr.r.rd),
        .wData  (wbData),
        .rData1 (rData1),
        .rData2 (rData2)
    );

    Alu uAlu (
        .aluOp  (aluOp),
        .a      (rData1),
        .b      (aluB),
        .result (aluResult)
    );

    assign dataAddr  = aluResult;
    assign dataWData = rData2;

    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("PC lost word alignment.");

endmodule

/* rtl/ControlUnit.sv */
`timescale 1ns/100ps

module ControlUnit import riscvPkg::*; (
    input  logic   reset,
    input  instr_t instr,
    output logic   regWe,
    output aluOp_t aluOp,
    output logic   aluSrcImm,
    output logic   memToReg,
    output logic   dataWe
);
    logic supported;

    // Bit 30 picks sub only for R-type, but picks sra for both formats.
    function automatic aluOp_t decodeAlu(input logic [2:0] funct3, input logic bit30,
                                         input logic isR);
        aluOp_t op;
        case (funct3)
            f3AddSub: op = (isR && bit30) ? aluSub : aluAdd;
            f3Sll:    op = aluSll;
            f3Slt:    op = aluSlt;
            f3Sltu:   op = aluSltu;
            f3Xor:    op = aluXor;
            f3SrlSra: op = bit30 ? aluSra : aluSrl;
            f3Or:     op = aluOr;
            f3And:    op = aluAnd;
            default:  op = aluAdd;
        endcase
        return op;
    endfunction

    assign supported = instr.r.opcode inside {opR, opI, opLoad, opStore};

    always_comb begin
        regWe     = 1'b0;
        aluOp     = aluAdd;  // Loads and stores form the address with an add.
        aluSrcImm = 1'b0;
        memToReg  = 1'b0;
        dataWe    = 1'b0;
        case (instr.r.opcode)
            opR: begin
                regWe = 1'b1;
                aluOp = decodeAlu(instr.r.funct3, instr.r.funct7[5], 1'b1);
            end
            opI: begin
                regWe     = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = decodeAlu(instr.i.funct3, instr.r.funct7[5], 1'b0);
            end
            opLoad: begin
                regWe     = 1'b1;
                aluSrcImm = 1'b1;
                memToReg  = 1'b1;
            end
            opStore: begin
                aluSrcImm = 1'b1;
                dataWe    = 1'b1;
            end
            default: ;
        endcase
        if (reset) begin
            regWe  = 1'b0;
            dataWe = 1'b0;
        end
    end

    always_comb begin
        assert final (supported || !(regWe || dataWe))
            else $error("Unsupported opcode %b caused a write.", instr.r.opcode);
    end

endmodule

/* rtl/InstrRom.sv */
`timescale 1ns/100ps

module InstrRom import riscvPkg::*; (
    input  logic [31:0] addr,
    output instr_t      instr
);
    logic [xlen-1:0] rom [romDepth];

    initial begin
        for (int k = 0; k < romDepth; k++) begin
            rom[k] = nopInstr;  // Words past the program stay no-ops.
        end
        $readmemh(romFile, rom);
    end

    assign instr = rom[addr[$clog2(romDepth)+1:2]];

endmodule

/* rtl/DataRam.sv */
`timescale 1ns/100ps

module DataRam import riscvPkg::*; (
    input  logic        clk,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    output logic [31:0] rData
);
    logic [xlen-1:0]             mem [ramDepth];
    logic [$clog2(ramDepth)-1:0] index;

    // Word index wraps at the memory depth.
    assign index = addr[$clog2(ramDepth)+1:2];

    initial begin
        for (int k = 0; k < ramDepth; k++) begin
            mem[k] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wData;
        end
    end

    assign rData = mem[index];

    assert property (@(posedge clk) we |-> addr[1:0] == 2'b00)
        else $error("Misaligned store to %h.", addr);

endmodule

/* rtl/RvSingleCycle.sv */
`timescale 1ns/100ps

module RvSingleCycle import riscvPkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pc,
    output logic        dataWe,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWData
);
    instr_t      instr;
    logic        regWe;
    aluOp_t      aluOp;
    logic        aluSrcImm;
    logic        memToReg;
    logic [31:0] ramRData;

    // ----------------------------------------
    // Fetch and decode
    // ----------------------------------------
    InstrRom uRom (
        .addr  (pc),
        .instr (instr)
    );

    ControlUnit uCtrl (
        .reset     (reset),
        .instr     (instr),
        .regWe     (regWe),
        .aluOp     (aluOp),
        .aluSrcImm (aluSrcImm),
        .memToReg  (memToReg),
        .dataWe    (dataWe)
    );

    // ----------------------------------------
    // Execute and memory
    // ----------------------------------------
    DataPath uPath (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .regWe     (regWe),
        .aluSrcImm (aluSrcImm),
        .memToReg  (memToReg),
        .aluOp     (aluOp),
        .ramRData  (ramRData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .dataWData (dataWData)
    );

    DataRam uRam (
        .clk   (clk),
        .we    (dataWe),
        .addr  (dataAddr),
        .wData (dataWData),
        .rData (ramRData)
    );

endmodule

/* dv/tbRvSingleCycle.sv */
`timescale 1ns/100ps

module tbRvSingleCycle import riscvPkg::*; ();

    localparam int resetCycles   = 5;
    localparam int programLength = 24;
    localparam int idleCycles    = 8;  // No-op words after the program.
    localparam int checkedCycles = programLength + idleCycles;
    localparam int timeoutCycles = 2 * (resetCycles + programLength + idleCycles);

    // What one instruction is expected to do.
    typedef struct packed {
        logic        storeValid;
        logic [31:0] addr;  // Expected dataAddr, which is the ALU result.
        logic [31:0] storeData;
        logic        regValid;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic [31:0] nextPc;
    } stepResult_t;

    logic        clk = 1'b0;  // Starts low so time zero has no falling edge.
    logic        reset;
    logic [31:0] pc;
    logic        dataWe;
    logic [31:0] dataAddr;
    logic [31:0] dataWData;

    logic [31:0] progMem [romDepth];
    logic [31:0] modelRegs [32];
    logic [31:0] modelRam [ramDepth];
    logic [31:0] modelPc;
    int          cycleCount = 0;

    RvSingleCycle DUT (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .dataWe    (dataWe),
        .dataAddr  (dataAddr),
        .dataWData (dataWData)
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic stepResult_t stepInstr(input logic [31:0] curPc, input instr_t ins,
                                              input logic [31:0] regs [32],
                                              input logic [31:0] ram [ramDepth]);
        stepResult_t res;
        logic [31:0] a;
        logic [31:0] rs2Val;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [4:0]  sh;
        logic        alt;
        a      = regs[ins.r.rs1];  // Entry 0 of the model stays zero.
        rs2Val = regs[ins.r.rs2];
        immI   = {{20{ins.i.imm[11]}}, ins.i.imm};
        immS   = {{20{ins.s.immHi[6]}}, ins.s.immHi, ins.s.immLo};
        b      = (ins.r.opcode == opR) ? rs2Val : immI;
        sh     = b[4:0];
        alt    = ins.r.funct7[5];
        res        = '0;
        res.nextPc = curPc + 32'd4;
        case (ins.r.opcode)
            opR, opI: begin
                case (ins.r.funct3)
                    3'b000: res.addr = (alt && ins.r.opcode == opR) ? a - b : a + b;
                    3'b001: res.addr = a << sh;
                    3'b010: res.addr = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011: res.addr = (a < b) ? 32'd1 : 32'd0;
                    3'b100: res.addr = a ^ b;
                    3'b101: begin
                        if (alt) begin
                            res.addr = $signed(a) >>> sh;
                        end else begin
                            res.addr = a >> sh;
                        end
                    end
                    3'b110: res.addr = a | b;
                    default: res.addr = a & b;
                endcase
                res.regValid = 1'b1;
                res.regData  = res.addr;
            end
            opLoad: begin
                res.addr     = a + immI;
                res.regValid = 1'b1;
                res.regData  = ram[(res.addr >> 2) % ramDepth];
            end
            opStore: begin
                res.addr       = a + immS;
                res.storeValid = 1'b1;
                res.storeData  = rs2Val;
            end
            default: ;
        endcase
        res.regAddr  = ins.r.rd;
        res.regValid = res.regValid && (ins.r.rd != 5'd0);  // Writes to x0 vanish.
        return res;
    endfunction

    task automatic loadModel();
        for (int k = 0; k < romDepth; k++) begin
            progMem[k] = nopInstr;
        end
        $readmemh(romFile, progMem);
        for (int k = 0; k < 32; k++) begin
            modelRegs[k] = (k == 0) ? 32'd0 : 32'(10 + k);
        end
        for (int k = 0; k < ramDepth; k++) begin
            modelRam[k] = '0;
        end
        modelPc = '0;
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic stopRun(input string reason);
        $display("Simulation FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            stopRun("Output value mismatch.");
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", name, expected, actual);
            stopRun("Output value mismatch.");
        end
    endtask

    initial begin
        reset = 1'b1;
        loadModel();
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;
    end

    // Outputs settle after each rising edge, so they are sampled on the falling edge.
    initial begin : compareOutputs
        stepResult_t expected;
        instr_t      ins;
        string       tag;
        @(negedge clk);
        while (reset) begin
            checkWord("reset pc", 32'd0, pc);
            checkBit("reset dataWe", 1'b0, dataWe);
            @(negedge clk);
        end
        for (int step = 0; step < checkedCycles; step++) begin
            ins      = progMem[(modelPc >> 2) % romDepth];
            expected = stepInstr(modelPc, ins, modelRegs, modelRam);
            tag      = $sformatf("step %0d", step);
            checkWord({tag, " pc"}, modelPc, pc);
            checkBit({tag, " dataWe"}, expected.storeValid, dataWe);
            checkWord({tag, " dataAddr"}, expected.addr, dataAddr);
            if (expected.storeValid) begin
                checkWord({tag, " dataWData"}, expected.storeData, dataWData);
                modelRam[(expected.addr >> 2) % ramDepth] = expected.storeData;
            end
            if (expected.regValid) begin
                modelRegs[expected.regAddr] = expected.regData;
            end
            modelPc = expected.nextPc;
            @(negedge clk);
        end
        $display("Simulation PASSED");
        $finish;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("The run did not finish within %0d cycles.", timeoutCycles);
            stopRun("Timeout.");
        end
    end

endmodule

/* program.hex */
// One instruction word per line in hex, starting at address 0.
FEC00093  // addi  x1, x0, -20
40118133  // sub   x2, x3, x1
00508233  // add   x4, x1, x5
007312B3  // sll   x5, x6, x7
0030A333  // slt   x6, x1, x3
0030B433  // sltu  x8, x1, x3
00A0C4B3  // xor   x9, x1, x10
00B0D533  // srl   x10, x1, x11
40D0D5B3  // sra   x11, x1, x13
00D1E633  // or    x12, x3, x13
00E0F6B3  // and   x13, x1, x14
FED0A713  // slti  x14, x1, -19
FFF1B793  // sltiu x15, x3, -1
FFF0C013  // xori  x0, x1, -1
7001E893  // ori   x17, x3, 0x700
0F00F913  // andi  x18, x1, 0x0f0
01F19993  // slli  x19, x3, 31
41F0DA13  // srai  x20, x1, 31
0040DA93  // srli  x21, x1, 4
FE7B2E23  // sw    x7, -4(x22)
01C02B83  // lw    x23, 28(x0)
01702223  // sw    x23, 4(x0)
02802C03  // lw    x24, 40(x0)
000C2623  // sw    x0, 12(x24)

/* all.f */
rtl/riscvPkg.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/DataPath.sv
rtl/ControlUnit.sv
rtl/InstrRom.sv
rtl/DataRam.sv
rtl/RvSingleCycle.sv
dv/tbRvSingleCycle.sv

/* Bender.yml */
package:
  name: rv_single_cycle

sources:
  - rtl/riscvPkg.sv
  - rtl/Alu.sv
  - rtl/RegisterFile.sv
  - rtl/DataPath.sv
  - rtl/ControlUnit.sv
  - rtl/InstrRom.sv
  - rtl/DataRam.sv
  - rtl/RvSingleCycle.sv
  - target: test
    files:
      - dv/tbRvSingleCycle.sv
